// File: hdl/aluPkg.sv
`default_nettype none

package aluPkg;

	//////////////////////////////////////////////////
	// Datapath sizes
	//////////////////////////////////////////////////

	// Data word
	localparam int wordWidth = 16;
	// Register file depth and index
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;
	// Opcode field
	localparam int opcodeWidth = 8;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	// Add family
	localparam logic [opcodeWidth-1:0] opADD = 8'd0;
	localparam logic [opcodeWidth-1:0] opADDU = 8'd1;
	localparam logic [opcodeWidth-1:0] opADDI = 8'd2;
	localparam logic [opcodeWidth-1:0] opADDUI = 8'd3;
	// Add with stored carry
	localparam logic [opcodeWidth-1:0] opADDC = 8'd4;
	localparam logic [opcodeWidth-1:0] opADDCU = 8'd5;
	localparam logic [opcodeWidth-1:0] opADDCUI = 8'd6;
	localparam logic [opcodeWidth-1:0] opADDCI = 8'd7;
	// Subtract and compare
	localparam logic [opcodeWidth-1:0] opSUB = 8'd8;
	localparam logic [opcodeWidth-1:0] opSUBI = 8'd9;
	localparam logic [opcodeWidth-1:0] opCMP = 8'd10;
	localparam logic [opcodeWidth-1:0] opCMPI = 8'd11;
	localparam logic [opcodeWidth-1:0] opCMPUI = 8'd12;
	// Bitwise logic
	localparam logic [opcodeWidth-1:0] opAND = 8'd13;
	localparam logic [opcodeWidth-1:0] opOR = 8'd14;
	localparam logic [opcodeWidth-1:0] opXOR = 8'd15;
	localparam logic [opcodeWidth-1:0] opNOT = 8'd16;
	// Shifts, amount from B[3:0]
	localparam logic [opcodeWidth-1:0] opLSH = 8'd17;
	localparam logic [opcodeWidth-1:0] opLSHI = 8'd18;
	localparam logic [opcodeWidth-1:0] opRSH = 8'd19;
	localparam logic [opcodeWidth-1:0] opRSHI = 8'd20;
	localparam logic [opcodeWidth-1:0] opALSH = 8'd21;
	localparam logic [opcodeWidth-1:0] opARSH = 8'd22;
	// Idle and register load
	localparam logic [opcodeWidth-1:0] opNOP = 8'd23;
	localparam logic [opcodeWidth-1:0] opMOVI = 8'd24;

	//////////////////////////////////////////////////
	// Status flags
	//////////////////////////////////////////////////

	localparam int flagCount = 5;
	// Bit positions in the flag vector
	localparam int flagCarry = 0;
	localparam int flagLow = 1;
	localparam int flagFlag = 2;
	localparam int flagNeg = 3;
	localparam int flagZero = 4;

endpackage

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
(
	input wire [aluPkg::wordWidth-1:0] readA,
	input wire [aluPkg::wordWidth-1:0] readB,
	input wire [aluPkg::wordWidth-1:0] imm,
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire carryIn,
	output logic [aluPkg::wordWidth-1:0] aluResult,
	output logic [aluPkg::flagCount-1:0] aluFlags,
	output logic [aluPkg::flagCount-1:0] flagMask,
	output logic writeEn
);

	import aluPkg::*;

	// Second operand after the immediate select
	logic [wordWidth-1:0] opB;
	logic useImm;
	// Stored carry enters only the ADDC forms
	logic useCarry;
	logic [wordWidth:0] carryAdd;
	// Adder keeps its carry out in the top bit
	logic [wordWidth:0] sumWide;
	logic [wordWidth-1:0] diff;
	logic addOvf;
	logic subOvf;
	logic [3:0] shiftAmt;
	// Compares set Zero from equality
	logic isCompare;

	//////////////////////////////////////////////////
	// Operand select
	//////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			opADDI, opADDUI, opADDCUI, opADDCI, opSUBI,
			opCMPI, opCMPUI, opLSHI, opRSHI, opMOVI:
				useImm = 1'b1;
			default:
				useImm = 1'b0;
		endcase
	end

	assign opB = useImm ? imm : readB;
	assign useCarry = (opcode == opADDC) || (opcode == opADDCU) ||
		(opcode == opADDCUI) || (opcode == opADDCI);
	assign carryAdd = {{wordWidth{1'b0}}, useCarry & carryIn};

	// Shared adder and subtractor
	assign sumWide = {1'b0, readA} + {1'b0, opB} + carryAdd;
	assign diff = readA - opB;

	// Signed overflow, operands alike in sign and result not
	assign addOvf = (readA[wordWidth-1] == opB[wordWidth-1]) &&
		(sumWide[wordWidth-1] != readA[wordWidth-1]);
	// For subtract the signs must differ
	assign subOvf = (readA[wordWidth-1] != opB[wordWidth-1]) &&
		(diff[wordWidth-1] != readA[wordWidth-1]);

	assign shiftAmt = opB[3:0];

	//////////////////////////////////////////////////
	// Result, flags and update mask
	//////////////////////////////////////////////////

	always_comb
	begin
		aluResult = '0;
		aluFlags = '0;
		flagMask = '0;
		writeEn = 1'b0;
		isCompare = 1'b0;
		case (opcode)
			// Signed adds report overflow
			opADD, opADDI, opADDC, opADDCI:
			begin
				aluResult = sumWide[wordWidth-1:0];
				aluFlags[flagFlag] = addOvf;
				flagMask[flagFlag] = 1'b1;
				flagMask[flagZero] = 1'b1;
				writeEn = 1'b1;
			end
			// Unsigned adds report carry out
			opADDU, opADDUI, opADDCU, opADDCUI:
			begin
				aluResult = sumWide[wordWidth-1:0];
				aluFlags[flagCarry] = sumWide[wordWidth];
				flagMask[flagCarry] = 1'b1;
				flagMask[flagZero] = 1'b1;
				writeEn = 1'b1;
			end
			opSUB, opSUBI:
			begin
				aluResult = diff;
				aluFlags[flagFlag] = subOvf;
				flagMask[flagFlag] = 1'b1;
				flagMask[flagZero] = 1'b1;
				writeEn = 1'b1;
			end
			// Compare sets ordering flags only, no write
			opCMP, opCMPI, opCMPUI:
			begin
				aluResult = diff;
				isCompare = 1'b1;
				aluFlags[flagZero] = (readA == opB);
				aluFlags[flagNeg] = ($signed(readA) < $signed(opB));
				aluFlags[flagLow] = (readA < opB);
				flagMask[flagZero] = 1'b1;
				flagMask[flagNeg] = 1'b1;
				flagMask[flagLow] = 1'b1;
			end
			opAND, opOR, opXOR, opNOT,
			opLSH, opLSHI, opALSH, opRSH, opRSHI, opARSH:
			begin
				case (opcode)
					opAND: aluResult = readA & opB;
					opOR: aluResult = readA | opB;
					opXOR: aluResult = readA ^ opB;
					opNOT: aluResult = ~readA;
					opRSH, opRSHI: aluResult = readA >> shiftAmt;
					opARSH: aluResult = $signed(readA) >>> shiftAmt;
					default: aluResult = readA << shiftAmt;
				endcase
				flagMask[flagZero] = 1'b1;
				writeEn = 1'b1;
			end
			// Register load, flags untouched
			opMOVI:
			begin
				aluResult = imm;
				writeEn = 1'b1;
			end
			// NOP and anything past MOVI
			default:
			begin
				aluResult = '0;
			end
		endcase
		// Zero from the result unless a compare set it
		if (!isCompare)
			aluFlags[flagZero] = (aluResult == '0);
	end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
(
	input wire clk,
	input wire rst,
	input wire [aluPkg::regAddrWidth-1:0] rdAddrA,
	input wire [aluPkg::regAddrWidth-1:0] rdAddrB,
	output logic [aluPkg::wordWidth-1:0] readA,
	output logic [aluPkg::wordWidth-1:0] readB,
	input wire wrEn,
	input wire [aluPkg::regAddrWidth-1:0] wrAddr,
	input wire [aluPkg::wordWidth-1:0] wrData
);

	import aluPkg::*;

	// Register storage
	logic [wordWidth-1:0] regs [regCount];

	// Bypass hits per read port
	logic hitA;
	logic hitB;

	// Write port, all registers zero after reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Pending write-back wins over the stored word
	assign hitA = wrEn && (wrAddr == rdAddrA);
	assign hitB = wrEn && (wrAddr == rdAddrB);

	// Combinational reads
	assign readA = hitA ? wrData : regs[rdAddrA];
	assign readB = hitB ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// File: hdl/statusReg.sv
`timescale 1ns/1ps
`default_nettype none

module statusReg
(
	input wire clk,
	input wire rst,
	input wire update,
	input wire [aluPkg::flagCount-1:0] newFlags,
	input wire [aluPkg::flagCount-1:0] flagMask,
	output logic [aluPkg::flagCount-1:0] flags,
	output logic carryIn
);

	import aluPkg::*;

	// Masked merge of old and new flags
	logic [flagCount-1:0] mergedFlags;

	// Unmasked bits keep their stored value
	assign mergedFlags = (flags & ~flagMask) | (newFlags & flagMask);

	//////////////////////////////////////////////////
	// Flag storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			flags <= '0;
		end
		else if (update)
		begin
			flags <= mergedFlags;
		end
	end

	// Stored carry back to the adder
	assign carryIn = flags[flagCarry];

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit
(
	input wire clk,
	input wire rst,
	input wire instValid,
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire [aluPkg::regAddrWidth-1:0] rDest,
	input wire [aluPkg::regAddrWidth-1:0] rSrcA,
	input wire [aluPkg::regAddrWidth-1:0] rSrcB,
	input wire [aluPkg::wordWidth-1:0] imm,
	output logic [aluPkg::wordWidth-1:0] result,
	output logic [aluPkg::regAddrWidth-1:0] resultDest,
	output logic resultValid,
	output logic carry,
	output logic low,
	output logic flag,
	output logic negative,
	output logic zero
);

	import aluPkg::*;

	// Operands from the register file
	logic [wordWidth-1:0] readA;
	logic [wordWidth-1:0] readB;
	// ALU outputs
	logic [wordWidth-1:0] aluResult;
	logic [flagCount-1:0] aluFlags;
	logic [flagCount-1:0] flagMask;
	logic writeEn;
	// Status register
	logic [flagCount-1:0] flags;
	logic carryIn;
	// Write-back stage
	logic wbValid;
	logic [regAddrWidth-1:0] wbDest;
	logic [wordWidth-1:0] wbData;

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	regFile i_regFile (.clk(clk), .rst(rst), .rdAddrA(rSrcA), .rdAddrB(rSrcB),
		.readA(readA), .readB(readB), .wrEn(wbValid), .wrAddr(wbDest), .wrData(wbData));

	alu i_alu (.readA(readA), .readB(readB), .imm(imm), .opcode(opcode),
		.carryIn(carryIn), .aluResult(aluResult), .aluFlags(aluFlags),
		.flagMask(flagMask), .writeEn(writeEn));

	// Flags change with the issuing edge
	statusReg i_statusReg (.clk(clk), .rst(rst), .update(instValid),
		.newFlags(aluFlags), .flagMask(flagMask), .flags(flags), .carryIn(carryIn));

	//////////////////////////////////////////////////
	// Write-back register
	//////////////////////////////////////////////////

	// Valid only for writing opcodes
	always_ff @(posedge clk)
	begin
		if (rst)
			wbValid <= 1'b0;
		else
			wbValid <= instValid & writeEn;
	end

	// payload follows every issue
	always_ff @(posedge clk)
	begin
		wbDest <= rDest;
		wbData <= aluResult;
	end

	// Result outputs straight from the stage
	assign result = wbData;
	assign resultDest = wbDest;
	assign resultValid = wbValid;
	// Flag outputs
	assign carry = flags[flagCarry];
	assign low = flags[flagLow];
	assign flag = flags[flagFlag];
	assign negative = flags[flagNeg];
	assign zero = flags[flagZero];

endmodule

`default_nettype wire

// File: tests/execUnit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module execUnitAssert
(
	input wire clk,
	input wire rst,
	input wire instValid,
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire resultValid
);

	import aluPkg::*;

	// Compares, NOP and opcodes past MOVI
	logic noWrite;

	assign noWrite = (opcode == opCMP) || (opcode == opCMPI) || (opcode == opCMPUI) ||
		(opcode == opNOP) || (opcode > opMOVI);

	// Write-back stage idle through reset
	resetIdle: assert property (@(posedge clk) rst |=> !resultValid)
		else $error("resultValid high after a reset cycle");

	// No result for non-writing opcodes
	noWriteIdle: assert property (@(posedge clk) disable iff (rst)
		instValid && noWrite |=> !resultValid)
		else $error("resultValid rose for a compare or NOP");

	// Writing issue gives a result one cycle later
	writeFollows: assert property (@(posedge clk) disable iff (rst)
		instValid && !noWrite |=> resultValid)
		else $error("resultValid missing after a writing issue");

	idleQuiet: assert property (@(posedge clk) disable iff (rst)
		!instValid |=> !resultValid)
		else $error("resultValid high without an issue");

endmodule

`default_nettype wire

// File: tests/execUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module execUnitTb;

	import aluPkg::*;

	localparam int clkPeriod = 10;
	localparam int resetCycles = 10;
	localparam int randCount = 40;
	// MOVI loads, four random loops and the directed issues
	localparam int plannedInst = regCount + 4 * randCount + 16;
	localparam int watchdogNs = (plannedInst + resetCycles) * clkPeriod * 4 + 500;

	logic clk, rst, instValid;
	logic [opcodeWidth-1:0] opcode;
	logic [regAddrWidth-1:0] rDest, rSrcA, rSrcB;
	logic [wordWidth-1:0] imm;
	logic [wordWidth-1:0] result;
	logic [regAddrWidth-1:0] resultDest;
	logic resultValid, carry, low, flag, negative, zero;
	// DUT flag outputs gathered by bit position
	logic [flagCount-1:0] dutFlags;
	// Reference model state
	logic [wordWidth-1:0] modelRegs [regCount];
	logic [flagCount-1:0] modelFlags;
	int seed;

	execUnit i_execUnit (.clk(clk), .rst(rst), .instValid(instValid), .opcode(opcode),
		.rDest(rDest), .rSrcA(rSrcA), .rSrcB(rSrcB), .imm(imm), .result(result),
		.resultDest(resultDest), .resultValid(resultValid), .carry(carry), .low(low),
		.flag(flag), .negative(negative), .zero(zero));

	bind execUnit execUnitAssert i_execUnitAssert (.clk(clk), .rst(rst),
		.instValid(instValid), .opcode(opcode), .resultValid(resultValid));

	always_comb
	begin
		dutFlags[flagCarry] = carry;
		dutFlags[flagLow] = low;
		dutFlags[flagFlag] = flag;
		dutFlags[flagNeg] = negative;
		dutFlags[flagZero] = zero;
	end

	//////////////////////////////////////////////////
	// Error stop and compare tasks
	//////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkWord(input string name, input logic [wordWidth-1:0] expected,
		input logic [wordWidth-1:0] actual);
		if (actual !== expected)
			abortRun($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual));
	endtask

	task automatic checkDest(input string name, input logic [regAddrWidth-1:0] expected,
		input logic [regAddrWidth-1:0] actual);
		if (actual !== expected)
			abortRun($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual));
	endtask

	task automatic checkFlags(input string name, input logic [flagCount-1:0] expected,
		input logic [flagCount-1:0] actual);
		if (actual !== expected)
			abortRun($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual));
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual));
	endtask

	function automatic logic [wordWidth-1:0] randWord();
		int r;
		r = $random(seed);
		return r[wordWidth-1:0];
	endfunction

	function automatic logic [regAddrWidth-1:0] randReg();
		logic [wordWidth-1:0] w;
		w = randWord();
		return w[regAddrWidth-1:0];
	endfunction

	//////////////////////////////////////////////////
	// Issue one instruction against the model
	//////////////////////////////////////////////////

	// Entered 1 ns after a rising edge, returns 1 ns after the next one
	task automatic issue(input logic [opcodeWidth-1:0] op, input logic [regAddrWidth-1:0] dst,
		input logic [regAddrWidth-1:0] srcA, input logic [regAddrWidth-1:0] srcB,
		input logic [wordWidth-1:0] immVal);
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		logic [wordWidth-1:0] expected;
		logic [flagCount-1:0] expFlags;
		logic writes;
		int wide;
		int cin;
		a = modelRegs[srcA];
		b = modelRegs[srcB];
		if (op inside {opADDI, opADDUI, opADDCUI, opADDCI, opSUBI, opCMPI, opCMPUI, opLSHI, opRSHI})
			b = immVal;
		cin = (op inside {opADDC, opADDCU, opADDCUI, opADDCI}) ? int'(modelFlags[flagCarry]) : 0;
		writes = !(op inside {opCMP, opCMPI, opCMPUI, opNOP}) && (op <= opMOVI);
		expFlags = modelFlags;
		wide = 0;
		// Sums in 32 bits, overflow is a range check
		case (op)
			opADD, opADDI, opADDC, opADDCI:
			begin
				wide = int'($signed(a)) + int'($signed(b)) + cin;
				expFlags[flagFlag] = (wide > 32767) || (wide < -32768);
			end
			opADDU, opADDUI, opADDCU, opADDCUI:
			begin
				wide = int'(a) + int'(b) + cin;
				expFlags[flagCarry] = wide > 65535;
			end
			opSUB, opSUBI:
			begin
				wide = int'($signed(a)) - int'($signed(b));
				expFlags[flagFlag] = (wide > 32767) || (wide < -32768);
			end
			opCMP, opCMPI, opCMPUI:
			begin
				expFlags[flagZero] = a == b;
				expFlags[flagNeg] = int'($signed(a)) < int'($signed(b));
				expFlags[flagLow] = int'(a) < int'(b);
			end
			opAND: wide = int'(a & b);
			opOR: wide = int'(a | b);
			opXOR: wide = int'(a ^ b);
			opNOT: wide = int'(~a);
			opLSH, opLSHI, opALSH: wide = int'(a) << b[3:0];
			opRSH, opRSHI: wide = int'(a) >> b[3:0];
			opARSH: wide = int'($signed(a)) >>> b[3:0];
			opMOVI: wide = int'(immVal);
			default: wide = 0;
		endcase
		expected = wide[wordWidth-1:0];
		if (writes && (op != opMOVI))
			expFlags[flagZero] = expected == '0;
		instValid = 1'b1;
		opcode = op;
		rDest = dst;
		rSrcA = srcA;
		rSrcB = srcB;
		imm = immVal;
		@(posedge clk);
		#1;
		instValid = 1'b0;
		// Forwarding makes the write visible to the next issue
		if (writes)
			modelRegs[dst] = expected;
		modelFlags = expFlags;
		checkBit("resultValid", writes, resultValid);
		if (writes)
		begin
			checkWord("result", expected, result);
			checkDest("resultDest", dst, resultDest);
		end
		checkFlags("flags", modelFlags, dutFlags);
	endtask

	// One cycle without an issue, nothing may change
	task automatic idleCycle();
		@(posedge clk);
		#1;
		checkBit("resultValid", 1'b0, resultValid);
		checkFlags("flags", modelFlags, dutFlags);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic resetLoadTest();
		checkBit("resultValid", 1'b0, resultValid);
		checkFlags("flags", '0, dutFlags);
		for (int i = 0; i < regCount; i++)
			issue(opMOVI, 4'(i), 4'd0, 4'd0, randWord());
	endtask

	task automatic addTest();
		logic [wordWidth-1:0] r;
		// Carry out of 0xffff + 1, then stored carry into ADDC and ADDCUI
		issue(opMOVI, 4'd1, 4'd0, 4'd0, 16'hffff);
		issue(opADDUI, 4'd2, 4'd1, 4'd0, 16'h0001);
		issue(opADDC, 4'd3, 4'd1, 4'd1, 16'h0000);
		issue(opADDCUI, 4'd4, 4'd1, 4'd0, 16'h0000);
		// Signed overflow of 0x7fff + 1
		issue(opMOVI, 4'd5, 4'd0, 4'd0, 16'h7fff);
		issue(opADDI, 4'd6, 4'd5, 4'd0, 16'h0001);
		for (int i = 0; i < randCount; i++)
		begin
			r = randWord();
			issue(opADD + {5'd0, r[2:0]}, randReg(), randReg(), randReg(), randWord());
		end
	endtask

	task automatic subCmpTest();
		logic [wordWidth-1:0] r;
		// Equal, signed-less and unsigned-less
		issue(opMOVI, 4'd7, 4'd0, 4'd0, 16'h8000);
		issue(opCMP, 4'd0, 4'd7, 4'd7, 16'h0000);
		issue(opCMPI, 4'd0, 4'd7, 4'd0, 16'h0001);
		issue(opCMPUI, 4'd0, 4'd5, 4'd0, 16'h8000);
		issue(opSUBI, 4'd8, 4'd7, 4'd0, 16'h0001);
		for (int i = 0; i < randCount; i++)
		begin
			r = randWord();
			issue(opSUB + (r[7:0] % 8'd5), randReg(), randReg(), randReg(), randWord());
		end
	endtask

	task automatic logicShiftTest();
		logic [wordWidth-1:0] r;
		issue(opXOR, 4'd9, 4'd1, 4'd1, 16'h0000);
		issue(opARSH, 4'd10, 4'd7, 4'd1, 16'h0000);
		for (int i = 0; i < randCount; i++)
		begin
			r = randWord();
			issue(opAND + (r[7:0] % 8'd10), randReg(), randReg(), randReg(), randWord());
		end
	endtask

	task automatic chainTest();
		logic [regAddrWidth-1:0] prev;
		logic [regAddrWidth-1:0] dst;
		logic [wordWidth-1:0] r;
		logic [opcodeWidth-1:0] op;
		prev = 4'd3;
		for (int i = 0; i < randCount; i++)
		begin
			r = randWord();
			dst = randReg();
			// Every fifth slot idles as NOP or an unused opcode
			if (i % 5 == 4)
				issue(r[0] ? opNOP : 8'd200, dst, prev, prev, r);
			else
			begin
				op = opADD + (r[7:0] % 8'd23);
				issue(op, dst, prev, randReg(), randWord());
				// Compares leave no destination to chain on
				if (!(op inside {opCMP, opCMPI, opCMPUI}))
					prev = dst;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	// Watchdog
	initial
	begin
		#(watchdogNs);
		abortRun("Watchdog expired before the tests finished");
	end

	initial
	begin
		seed = 32'h738aeebf;
		rst = 1'b1;
		instValid = 1'b0;
		opcode = opNOP;
		rDest = '0;
		rSrcA = '0;
		rSrcB = '0;
		imm = '0;
		modelFlags = '0;
		for (int i = 0; i < regCount; i++)
			modelRegs[i] = '0;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;
		resetLoadTest();
		idleCycle();
		addTest();
		idleCycle();
		subCmpTest();
		idleCycle();
		logicShiftTest();
		idleCycle();
		chainTest();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hdl/aluPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/statusReg.sv
hdl/execUnit.sv
tests/execUnit_assert.sv
tests/execUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

topModule=execUnitTb
logFile=sim.log

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
	--top-module "$topModule" -f filelist.f -o "$topModule"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$topModule" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

# Pass only when the testbench printed its pass line
if grep -q "=== PASS ===" "$logFile"; then
	exit 0
fi
echo "Pass line not found in $logFile"
exit 1
